// ==== filelist.f ====
design/vga_pkg.sv
design/hack_pkg.sv
design/vga_timing.sv
design/screen_ram.sv
design/register_display.sv
design/frame_buffer.sv
design/hack_display_top.sv
dv/tb_clock.sv
dv/hack_display_tb.sv

// ==== Bender.yml ====
package:
  name: hack_display

sources:
  - design/vga_pkg.sv
  - design/hack_pkg.sv
  - design/vga_timing.sv
  - design/screen_ram.sv
  - design/register_display.sv
  - design/frame_buffer.sv
  - design/hack_display_top.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/hack_display_tb.sv

// ==== dv/hack_display_tb.sv ====
// hack_display_tb: stimulus, reference pixel model, per-cycle compare, checker and watchdog
module hack_display_tb;

    localparam int CLK_PERIOD = 4;
    localparam int SEED       = 67;
    localparam int H_TOTAL    = vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC
                              + vga_pkg::H_BACK;
    localparam int V_TOTAL    = vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC
                              + vga_pkg::V_BACK;
    localparam int FRAME      = H_TOTAL * V_TOTAL;  // cycles per frame
    localparam int WIN_H0     = vga_pkg::WIN_H0;
    localparam int WIN_V0     = vga_pkg::WIN_V0;
    localparam int WORDS      = 2 ** hack_pkg::ADDR_W;
    localparam int BLANK_LINE = vga_pkg::V_ACTIVE + 10;  // well inside vertical blanking
    localparam int REWRITES   = 256;

    // first frame holds the fill, then three compared frames
    localparam int CHECK_FRAMES    = 3;
    localparam int FILL_CYCLES     = FRAME;
    localparam int END_CYCLE       = (CHECK_FRAMES + 1) * FRAME + 2;
    localparam int WATCHDOG_CYCLES = CHECK_FRAMES * FRAME + FILL_CYCLES + 1000;

    // font copy, bit (row, col) at 14 - 3*row - col
    localparam logic [14:0] FONT [16] = '{
        15'b111_101_101_101_111, 15'b010_110_010_010_111,
        15'b111_001_111_100_111, 15'b111_001_111_001_111,
        15'b101_101_111_001_001, 15'b111_100_111_001_111,
        15'b111_100_111_101_111, 15'b111_001_001_001_001,
        15'b111_101_111_101_111, 15'b111_101_111_001_111,
        15'b010_101_111_101_101, 15'b110_101_110_101_110,
        15'b111_100_100_100_111, 15'b110_101_101_101_110,
        15'b111_100_111_100_111, 15'b111_100_111_100_100
    };

    logic        clk;
    logic        arst_n;
    logic [12:0] write_address;
    logic [15:0] data_in;
    logic        load;
    logic [7:0]  keyboard;
    logic [15:0] instruction;
    logic [15:0] data_register;
    logic [2:0]  pixel_out;
    logic        hsync;
    logic        vsync;

    logic [15:0] shadow [WORDS];  // what the screen memory should hold
    int unsigned cycle;           // rising edges since reset release
    int          ref_h;
    int          ref_v;
    int          ref_frame;
    int          window_checks;
    int          glyph_checks;    // lit readout pixels compared
    int          hsync_lows;
    int          vsync_lows;

    tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_inst (.clk(clk));

    hack_display_top #(
        .H_ACTIVE(vga_pkg::H_ACTIVE), .H_FRONT(vga_pkg::H_FRONT),
        .H_SYNC(vga_pkg::H_SYNC), .H_BACK(vga_pkg::H_BACK),
        .V_ACTIVE(vga_pkg::V_ACTIVE), .V_FRONT(vga_pkg::V_FRONT),
        .V_SYNC(vga_pkg::V_SYNC), .V_BACK(vga_pkg::V_BACK)
    ) hack_display_top_inst (
        .clk(clk), .arst_n(arst_n),
        .write_address(write_address), .data_in(data_in), .load(load),
        .keyboard(keyboard), .instruction(instruction), .data_register(data_register),
        .pixel_out(pixel_out), .hsync(hsync), .vsync(vsync)
    );

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
        end
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s at h=%0d v=%0d frame=%0d: expected %0h, actual %0h",
                     name, ref_h, ref_v, ref_frame, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [15:0] readout_value(input int idx);
        case (idx)
            0:       return {8'h00, keyboard};  // key code padded to a word
            1:       return instruction;
            default: return data_register;
        endcase
    endfunction

    // pixel colour for raster position (h, v)
    function automatic logic [2:0] expected_pixel(input int h, input int v);
        int          rel_h;
        int          rel_v;
        int          top;
        int          k;
        int          c;
        int          i;
        logic [15:0] word;
        logic [3:0]  nib;
        if (h >= WIN_H0 && h < WIN_H0 + 512 && v >= WIN_V0 && v < WIN_V0 + 256) begin
            rel_h = h - WIN_H0;
            rel_v = v - WIN_V0;
            word  = shadow[rel_v * hack_pkg::ROW_WORDS + rel_h / 16];
            return word[rel_h % 16] ? vga_pkg::C_WHITE : vga_pkg::C_BLACK;  // bit 0 leftmost
        end
        for (i = 0; i < hack_pkg::NUM_READOUTS; i++) begin
            top = hack_pkg::READOUT_V0 + hack_pkg::READOUT_PITCH * i;
            if (h >= hack_pkg::READOUT_H0 && h < hack_pkg::READOUT_H0 + 16
                    && v >= top && v < top + 5) begin
                rel_h = h - hack_pkg::READOUT_H0;
                k     = rel_h / 4;  // digit, msb first
                c     = rel_h % 4;
                word  = readout_value(i);
                nib   = word[(15 - 4 * k) -: 4];
                if (c == 3) begin
                    return vga_pkg::C_BLACK;  // spacer
                end
                return FONT[nib][14 - 3 * (v - top) - c] ? vga_pkg::C_WHITE : vga_pkg::C_BLACK;
            end
        end
        return vga_pkg::C_BLUE;
    endfunction

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin : compare_outputs
        int unsigned pos;
        logic [2:0]  exp_pix;
        logic        exp_hs;
        logic        exp_vs;
        if (!arst_n || cycle < 2) begin
            ref_h     = 0;
            ref_v     = 0;
            ref_frame = 0;
            check_value("reset hsync", 16'd1, 16'(hsync));
            check_value("reset vsync", 16'd1, 16'(vsync));
            if (!arst_n || cycle == 0) begin
                check_value("reset pixel", 16'(vga_pkg::C_BLACK), 16'(pixel_out));
            end
        end else begin
            pos       = cycle - 2;  // outputs trail the counters by two cycles
            ref_frame = pos / FRAME;
            ref_v     = (pos % FRAME) / H_TOTAL;
            ref_h     = pos % H_TOTAL;
            exp_hs = !(ref_h >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT
                       && ref_h < vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC);
            exp_vs = !(ref_v >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT
                       && ref_v < vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC);
            check_value("hsync", 16'(exp_hs), 16'(hsync));
            check_value("vsync", 16'(exp_vs), 16'(vsync));
            hsync_lows += !exp_hs;
            vsync_lows += !exp_vs;
            if (ref_frame >= 1) begin  // memory is fully written by then
                exp_pix = expected_pixel(ref_h, ref_v);
                if (ref_h >= WIN_H0 && ref_h < WIN_H0 + 512
                        && ref_v >= WIN_V0 && ref_v < WIN_V0 + 256) begin
                    check_value("window pixel", 16'(exp_pix), 16'(pixel_out));
                    window_checks++;
                end else begin
                    check_value("border pixel", 16'(exp_pix), 16'(pixel_out));
                    glyph_checks += (exp_pix == vga_pkg::C_WHITE);
                end
            end
        end
    end

    task automatic wait_cycle(input int unsigned target);
        while (cycle < target) begin
            @(negedge clk);
        end
    endtask

    task automatic screen_write(input logic [12:0] addr, input logic [15:0] word);
        @(negedge clk);
        write_address = addr;
        data_in       = word;
        load          = 1'b1;
        shadow[addr]  = word;
    endtask

    task automatic new_register_values();
        keyboard      = 8'($urandom);
        instruction   = 16'($urandom);
        data_register = 16'($urandom);
    endtask

    initial begin : stimulus
        int          i;
        logic [12:0] addr;
        void'($urandom(SEED));
        arst_n        = 1'b0;
        write_address = '0;
        data_in       = '0;
        load          = 1'b0;
        window_checks = 0;
        glyph_checks  = 0;
        hsync_lows    = 0;
        vsync_lows    = 0;
        new_register_values();
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (i = 0; i < WORDS; i++) begin  // fill the whole screen in frame 0
            screen_write(13'(i), 16'($urandom));
        end
        @(negedge clk);
        load = 1'b0;
        wait_cycle(FRAME + BLANK_LINE * H_TOTAL);
        new_register_values();  // readouts redrawn in frame 2
        wait_cycle(2 * FRAME + BLANK_LINE * H_TOTAL);
        new_register_values();
        for (i = 0; i < REWRITES; i++) begin
            addr = 13'($urandom);
            screen_write(addr, shadow[addr] ^ (16'($urandom) | 16'd1));  // always changes
        end
        @(negedge clk);
        load = 1'b0;
        wait_cycle(END_CYCLE);
        if (window_checks == 0 || glyph_checks == 0 || hsync_lows == 0 || vsync_lows == 0) begin
            $display("some output region was never compared during the run");
            $display("TESTS FAILED");
            $fatal(1, "incomplete run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the test frames completed");
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

// ==== dv/tb_clock.sv ====
// tb_clock: free-running testbench clock source
module tb_clock #(
    parameter int PERIOD = 4  // time units per cycle
) (
    output logic clk
);

    initial begin
        clk = 1'b0;  // first edge is a rising one at PERIOD/2
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== design/hack_display_top.sv ====
// hack_display_top: timing generator, screen memory, debug readout array and frame buffer
module hack_display_top #(
    parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_pkg::H_FRONT,
    parameter int H_SYNC   = vga_pkg::H_SYNC,
    parameter int H_BACK   = vga_pkg::H_BACK,
    parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_pkg::V_FRONT,
    parameter int V_SYNC   = vga_pkg::V_SYNC,
    parameter int V_BACK   = vga_pkg::V_BACK
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [hack_pkg::ADDR_W-1:0]   write_address,  // cpu screen write
    input  logic [hack_pkg::WORD_W-1:0]   data_in,
    input  logic                         load,
    input  logic [7:0]                   keyboard,       // current key code
    input  logic [hack_pkg::WORD_W-1:0]   instruction,
    input  logic [hack_pkg::WORD_W-1:0]   data_register,
    output logic [vga_pkg::COLOUR_W-1:0]  pixel_out,
    output logic                         hsync,
    output logic                         vsync
);

    logic [vga_pkg::POS_W-1:0]     h_pos;
    logic [vga_pkg::POS_W-1:0]     v_pos;
    logic                          hsync_raw;
    logic                          vsync_raw;
    logic [hack_pkg::ADDR_W-1:0]    rd_address;
    logic [hack_pkg::WORD_W-1:0]    rd_data;
    logic [hack_pkg::WORD_W-1:0]    readout [hack_pkg::NUM_READOUTS];  // top to bottom
    logic [vga_pkg::COLOUR_W-1:0]   glyph_pixel [hack_pkg::NUM_READOUTS];
    logic [hack_pkg::NUM_READOUTS-1:0] glyph_on;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_inst (
        .clk(clk), .arst_n(arst_n),
        .h_pos(h_pos), .v_pos(v_pos),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw)
    );

    screen_ram screen_ram_inst (
        .clk(clk), .we(load), .write_address(write_address), .d(data_in),
        .read_address(rd_address), .q(rd_data)
    );

    // keyboard code padded up to a full word
    assign readout[0] = {{(hack_pkg::WORD_W - 8){1'b0}}, keyboard};
    assign readout[1] = instruction;
    assign readout[2] = data_register;

    for (genvar i = 0; i < hack_pkg::NUM_READOUTS; i++) begin : g_readout
        register_display #(
            .START_H(hack_pkg::READOUT_H0),
            .START_V(hack_pkg::READOUT_V0 + hack_pkg::READOUT_PITCH * i)
        ) register_display_inst (
            .clk(clk), .arst_n(arst_n),
            .h_pos(h_pos), .v_pos(v_pos),
            .value(readout[i]),
            .pixel(glyph_pixel[i]), .on(glyph_on[i])
        );
    end

    frame_buffer frame_buffer_inst (
        .clk(clk), .arst_n(arst_n),
        .h_pos(h_pos), .v_pos(v_pos),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw),
        .rd_address(rd_address), .rd_data(rd_data),
        .glyph_pixel(glyph_pixel), .glyph_on(glyph_on),
        .pixel_out(pixel_out), .hsync(hsync), .vsync(vsync)
    );

endmodule

// ==== design/frame_buffer.sv ====
// frame_buffer: screen address and bit decode, window/readout/background merge, pixel and sync pipeline
module frame_buffer (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [vga_pkg::POS_W-1:0]     h_pos,
    input  logic [vga_pkg::POS_W-1:0]     v_pos,
    input  logic                         hsync_raw,
    input  logic                         vsync_raw,
    output logic [hack_pkg::ADDR_W-1:0]   rd_address,
    input  logic [hack_pkg::WORD_W-1:0]   rd_data,    // one cycle after rd_address
    input  logic [vga_pkg::COLOUR_W-1:0]  glyph_pixel [hack_pkg::NUM_READOUTS],
    input  logic [hack_pkg::NUM_READOUTS-1:0] glyph_on,
    output logic [vga_pkg::COLOUR_W-1:0]  pixel_out,
    output logic                         hsync,
    output logic                         vsync
);

    localparam int BIT_W    = $clog2(hack_pkg::WORD_W);      // pixel within word
    localparam int COL_BITS = $clog2(hack_pkg::ROW_WORDS);   // word within row
    localparam int ROW_BITS = hack_pkg::ADDR_W - COL_BITS;   // screen row

    logic [vga_pkg::POS_W-1:0] h_rel;  // offset from window origin
    logic [vga_pkg::POS_W-1:0] v_rel;
    logic                      in_window;
    logic [BIT_W-1:0]          pix_bit;

    // stage 1, lined up with rd_data and the glyph outputs
    logic                      win_d;
    logic [BIT_W-1:0]          bit_d;
    logic                      hsync_d;
    logic                      vsync_d;

    logic [vga_pkg::COLOUR_W-1:0] border_pix;
    logic [vga_pkg::COLOUR_W-1:0] screen_pix;

    assign h_rel = h_pos - vga_pkg::WIN_H0;
    assign v_rel = v_pos - vga_pkg::WIN_V0;

    assign in_window = (h_pos >= vga_pkg::WIN_H0)
                    && (h_pos < vga_pkg::WIN_H0 + vga_pkg::WIN_W)
                    && (v_pos >= vga_pkg::WIN_V0)
                    && (v_pos < vga_pkg::WIN_V0 + vga_pkg::WIN_HT);

    // v_rel * 32 + h_rel / 16, as a concatenation since both are powers of two
    assign rd_address = {v_rel[ROW_BITS-1:0], h_rel[BIT_W +: COL_BITS]};
    assign pix_bit    = h_rel[BIT_W-1:0];  // hack order, bit 0 leftmost

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            win_d   <= 1'b0;
            bit_d   <= '0;
            hsync_d <= 1'b1;  // syncs idle high
            vsync_d <= 1'b1;
        end else begin
            win_d   <= in_window;
            bit_d   <= pix_bit;
            hsync_d <= hsync_raw;
            vsync_d <= vsync_raw;
        end
    end

    // lowest index wins, so walk down from the top
    always_comb begin
        border_pix = vga_pkg::C_BLUE;
        for (int i = hack_pkg::NUM_READOUTS - 1; i >= 0; i--) begin
            if (glyph_on[i]) begin
                border_pix = glyph_pixel[i];
            end
        end
    end

    assign screen_pix = rd_data[bit_d] ? vga_pkg::C_WHITE : vga_pkg::C_BLACK;

    // stage 2, output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pixel_out <= vga_pkg::C_BLACK;
            hsync     <= 1'b1;
            vsync     <= 1'b1;
        end else begin
            pixel_out <= win_d ? screen_pix : border_pix;
            hsync     <= hsync_d;
            vsync     <= vsync_d;
        end
    end

    // readout boxes from the top level must never overlap
    a_glyph_on_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(glyph_on));

endmodule

// ==== design/register_display.sv ====
// register_display: one 16-bit value drawn as four 3x5 hex glyphs in a fixed border box
module register_display #(
    parameter int START_H = hack_pkg::READOUT_H0,  // left column of the box
    parameter int START_V = hack_pkg::READOUT_V0   // top line of the box
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [vga_pkg::POS_W-1:0]     h_pos,
    input  logic [vga_pkg::POS_W-1:0]     v_pos,
    input  logic [hack_pkg::WORD_W-1:0]   value,  // held register level
    output logic [vga_pkg::COLOUR_W-1:0]  pixel,
    output logic                         on      // position was inside the box
);

    localparam int DIGITS     = hack_pkg::WORD_W / 4;
    localparam int BOX_W      = DIGITS * vga_pkg::CELL_W;  // 16 columns
    localparam int GLYPH_COLS = vga_pkg::CELL_W - 1;       // last column is spacer
    localparam int COL_BITS   = $clog2(vga_pkg::CELL_W);
    localparam int DIG_BITS   = $clog2(DIGITS);
    localparam int ROW_BITS   = $clog2(vga_pkg::CELL_HT);

    localparam logic [vga_pkg::POS_W-1:0] BOX_H0 = START_H[vga_pkg::POS_W-1:0];
    localparam logic [vga_pkg::POS_W-1:0] BOX_V0 = START_V[vga_pkg::POS_W-1:0];

    logic [vga_pkg::POS_W-1:0] rel_h;  // column inside the box
    logic [vga_pkg::POS_W-1:0] rel_v;  // row inside the box
    logic                      in_box;
    logic                      in_window;
    logic [DIG_BITS-1:0]       digit;  // 0 is the top nibble
    logic [COL_BITS-1:0]       col;
    logic [ROW_BITS-1:0]       row;
    logic [3:0]                nibble;
    logic [14:0]               glyph;
    logic                      lit;

    assign rel_h = h_pos - BOX_H0;
    assign rel_v = v_pos - BOX_V0;

    assign in_box = (h_pos >= BOX_H0) && (h_pos < START_H + BOX_W)
                 && (v_pos >= BOX_V0) && (v_pos < START_V + vga_pkg::CELL_HT);

    // cells are a power of two wide, so digit and column are plain slices
    assign digit = rel_h[COL_BITS +: DIG_BITS];
    assign col   = rel_h[COL_BITS-1:0];
    assign row   = rel_v[ROW_BITS-1:0];

    assign nibble = value[(DIGITS - 1 - digit) * 4 +: 4];  // msb nibble drawn first
    assign glyph  = vga_pkg::GLYPH[nibble];

    // spacer column never lights
    assign lit = (col < GLYPH_COLS) && glyph[14 - (row * 3 + col)];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            on    <= 1'b0;
            pixel <= vga_pkg::C_BLACK;
        end else begin
            on    <= in_box;
            pixel <= (in_box && lit) ? vga_pkg::C_WHITE : vga_pkg::C_BLACK;
        end
    end

    // only used by the check below
    assign in_window = (h_pos >= vga_pkg::WIN_H0)
                    && (h_pos < vga_pkg::WIN_H0 + vga_pkg::WIN_W)
                    && (v_pos >= vga_pkg::WIN_V0)
                    && (v_pos < vga_pkg::WIN_V0 + vga_pkg::WIN_HT);

    // box must sit in the border, frame_buffer ignores overlays in the window
    a_box_outside_window: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(on) |-> !$past(in_window));

endmodule

// ==== design/screen_ram.sv ====
// 8192 x 16 simple dual-port screen memory with one write port and a registered read port
module screen_ram (
    input  logic                       clk,
    input  logic                       we,             // cpu load strobe
    input  logic [hack_pkg::ADDR_W-1:0] write_address,
    input  logic [hack_pkg::WORD_W-1:0] d,              // 16 pixels with bit 0 leftmost
    input  logic [hack_pkg::ADDR_W-1:0] read_address,   // from the raster side
    output logic [hack_pkg::WORD_W-1:0] q
);

    localparam int DEPTH = 2 ** hack_pkg::ADDR_W;

    // one word per 16 screen pixels
    logic [hack_pkg::WORD_W-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[write_address] <= d;
        end
    end

    // registered read port returns the old word
    // when the same address is written in the same cycle
    always_ff @(posedge clk) begin
        q <= mem[read_address];
    end

    // a load with an unknown address would smear the whole screen in sim
    a_write_addr_known: assert property (@(posedge clk)
        we |-> !$isunknown(write_address));

endmodule

// ==== design/vga_timing.sv ====
// vga_timing: raster position counters and active-low horizontal/vertical sync decode
module vga_timing #(
    parameter int H_ACTIVE = vga_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_pkg::H_FRONT,
    parameter int H_SYNC   = vga_pkg::H_SYNC,
    parameter int H_BACK   = vga_pkg::H_BACK,
    parameter int V_ACTIVE = vga_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_pkg::V_FRONT,
    parameter int V_SYNC   = vga_pkg::V_SYNC,
    parameter int V_BACK   = vga_pkg::V_BACK
) (
    input  logic                     clk,
    input  logic                     arst_n,
    output logic [vga_pkg::POS_W-1:0] h_pos,  // pixel within line
    output logic [vga_pkg::POS_W-1:0] v_pos,  // line within frame
    output logic                     hsync_raw,
    output logic                     vsync_raw
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 1056 by default
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525 by default

    // sync windows follow the front porch
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    logic h_last;  // last pixel of the line
    logic v_last;  // last line of the frame

    assign h_last = (h_pos == H_TOTAL - 1);
    assign v_last = (v_pos == V_TOTAL - 1);

    // pixel counter, wraps every line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_pos <= '0;
        end else if (h_last) begin
            h_pos <= '0;
        end else begin
            h_pos <= h_pos + 1'b1;
        end
    end

    // line counter only moves on the horizontal wrap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v_pos <= '0;
        end else if (h_last) begin
            if (v_last) begin
                v_pos <= '0;
            end else begin
                v_pos <= v_pos + 1'b1;
            end
        end
    end

    // decoded straight from the counters, frame_buffer does the pipelining
    assign hsync_raw = !((h_pos >= HS_START) && (h_pos < HS_END));
    assign vsync_raw = !((v_pos >= VS_START) && (v_pos < VS_END));

    // the horizontal counter wraps before it can hit the total
    a_h_pos_range: assert property (@(posedge clk) disable iff (!arst_n)
        h_pos < H_TOTAL);

endmodule

// ==== design/hack_pkg.sv ====
// hack_pkg: hack machine word and screen sizes, debug readout placement
package hack_pkg;

    localparam int WORD_W = 16;  // hack word
    localparam int ADDR_W = 13;  // 8192 screen words

    // 512 pixels per row / 16 pixels per word
    localparam int ROW_WORDS = 32;

    // keyboard, instruction, data register
    localparam int NUM_READOUTS = 3;

    // readouts stack down the left border
    localparam int READOUT_H0    = 10;
    localparam int READOUT_V0    = 10;
    localparam int READOUT_PITCH = 10;  // lines between readout tops

endpackage

// ==== design/vga_pkg.sv ====
// vga_pkg: display timing defaults, window geometry, colour codes and the 3x5 hex font
package vga_pkg;

    // 800 x 480 timing, pixels and lines
    localparam int H_ACTIVE = 800;
    localparam int H_FRONT  = 40;
    localparam int H_SYNC   = 128;
    localparam int H_BACK   = 88;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 3;
    localparam int V_BACK   = 41;

    localparam int POS_W = 11;  // h/v counter width

    // hack screen window, centred in the active area
    localparam logic [POS_W-1:0] WIN_H0 = 11'd144;
    localparam logic [POS_W-1:0] WIN_V0 = 11'd112;
    localparam logic [POS_W-1:0] WIN_W  = 11'd512;
    localparam logic [POS_W-1:0] WIN_HT = 11'd256;

    localparam int COLOUR_W = 3;  // {r,g,b}
    localparam logic [COLOUR_W-1:0] C_BLACK = 3'b000;
    localparam logic [COLOUR_W-1:0] C_BLUE  = 3'b001;
    localparam logic [COLOUR_W-1:0] C_WHITE = 3'b111;

    localparam int CELL_W  = 4;  // 3 glyph columns + 1 blank spacer
    localparam int CELL_HT = 5;

    // glyph bit for (row, col) sits at 14 - (3*row + col), so literals read top-left first
    localparam logic [14:0] GLYPH [16] = '{
        15'b111_101_101_101_111, 15'b010_110_010_010_111,  // 0 1
        15'b111_001_111_100_111, 15'b111_001_111_001_111,  // 2 3
        15'b101_101_111_001_001, 15'b111_100_111_001_111,  // 4 5
        15'b111_100_111_101_111, 15'b111_001_001_001_001,  // 6 7
        15'b111_101_111_101_111, 15'b111_101_111_001_111,  // 8 9
        15'b010_101_111_101_101, 15'b110_101_110_101_110,  // a b
        15'b111_100_100_100_111, 15'b110_101_101_101_110,  // c d
        15'b111_100_111_100_111, 15'b111_100_111_100_100   // e f
    };

endpackage
